// ==== runSim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sim.f --top-module IntegerCoreTb \
	-o IntegerCoreSim > build.log 2>&1 \
	&& ./obj_dir/IntegerCoreSim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { cat sim.log; echo "Simulation failed"; exit 1; }

// ==== sim.f ====
verilog/coreTypes.sv
verilog/InstructionDecoder.sv
verilog/RegisterFile.sv
verilog/ExecuteUnit.sv
verilog/IntegerCore.sv
sim/IntegerCore_props.sv
sim/IntegerCoreTb.sv

// ==== sim/IntegerCoreTb.sv ====
module IntegerCoreTb import coreTypes::*;
();

	localparam int numInstructions = 2000;
	localparam int totalSteps = numInstructions + numInstructions / 64 + 1; // Plus x31 writes

	logic clock;
	logic reset;
	Word_t instruction;
	logic instructionValid;
	Word_t result;
	logic resultValid;
	RegAddress_t resultAddress;
	Word_t register31Output;

	integer seed = 32'h1d5a;
	Word_t model [0:31]; // Reference registers, x0 never written

	// What the outputs must show one cycle after the last driven step
	logic expectValid;
	Word_t expectResult;
	RegAddress_t expectAddress;
	string expectName;
	logic expectTop;

	IntegerCore IntegerCore_inst
	(
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.instructionValid(instructionValid),
		.result(result),
		.resultValid(resultValid),
		.resultAddress(resultAddress),
		.register31Output(register31Output)
	);

	always #4 clock = ~clock;

	function automatic int regIndex(input RegAddress_t address);
		return rv32i ? int'(address) : int'(address[3:0]);
	endfunction

	function automatic Word_t aluReference(input logic [2:0] f3, input logic alt,
		input Word_t a, input Word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic modelExecute(input Word_t instr, output logic legal, output Word_t value);
		logic [6:0] f7;
		logic [2:0] f3;
		Word_t a;
		f7 = instr[31:25];
		f3 = instr[14:12];
		a = model[regIndex(instr[19:15])];
		legal = 1'b0;
		value = '0;
		case (instr[6:0])
			7'h33:
			begin
				legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				value = aluReference(f3, f7[5], a, model[regIndex(instr[24:20])]);
			end
			7'h13:
			begin
				if (f3 == 3'd1)
					legal = (f7 == 7'h00);
				else if (f3 == 3'd5)
					legal = (f7 == 7'h00) || (f7 == 7'h20);
				else
					legal = 1'b1;
				value = aluReference(f3, f3 == 3'd5 && f7[5], a,
					{{20{instr[31]}}, instr[31:20]});
			end
			7'h37:
			begin
				legal = 1'b1;
				value = {instr[31:12], 12'h000};
			end
			default:
				legal = 1'b0; // Unsupported opcode
		endcase
	endtask

	task automatic checkValue(input string name, input Word_t expected, input Word_t actual);
		assert (expected === actual)
		else
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic checkOutputs();
		checkValue({expectName, " valid"}, Word_t'(expectValid), Word_t'(resultValid));
		if (expectValid)
		begin
			checkValue({expectName, " result"}, expectResult, result);
			checkValue({expectName, " address"}, Word_t'(expectAddress), Word_t'(resultAddress));
		end
		if (expectTop)
			checkValue("x31 observation", model[numRegs-1], register31Output);
	endtask

	// Check the previous step, then drive the next one
	task automatic applyStep(input Word_t instr, input logic valid, input string name,
		input logic checkTop);
		logic legal;
		Word_t value;
		@(negedge clock);
		checkOutputs();
		modelExecute(instr, legal, value);
		instruction = instr;
		instructionValid = valid;
		expectValid = valid && legal;
		expectResult = value;
		expectAddress = instr[11:7];
		expectName = name;
		expectTop = checkTop;
		if (expectValid && regIndex(instr[11:7]) != 0)
			model[regIndex(instr[11:7])] = value;
	endtask

	// Mostly low registers so that results feed later instructions
	function automatic RegAddress_t randomAddress();
		Word_t r;
		r = $random(seed);
		return (r[1:0] == 2'd0) ? r[8:4] : {2'b00, r[6:4]};
	endfunction

	function automatic logic [6:0] pickFunct7();
		Word_t r;
		r = $random(seed);
		if (r[2:0] < 3'd5)
			return 7'h00;
		else if (r[2:0] < 3'd7)
			return 7'h20;
		return r[15:9]; // Usually illegal
	endfunction

	task automatic generateInstruction(output Word_t instr, output string name);
		Word_t r;
		int cls;
		cls = $unsigned($random(seed)) % 8;
		r = $random(seed);
		instr = r;
		instr[19:15] = randomAddress();
		instr[24:20] = randomAddress();
		instr[11:7] = randomAddress();
		if (cls < 3)
		begin
			instr[6:0] = 7'h33;
			instr[31:25] = pickFunct7();
			name = "register-register";
		end
		else if (cls < 5)
		begin
			instr[6:0] = 7'h13;
			if (instr[14:12] == 3'd1 || instr[14:12] == 3'd5)
				instr[31:25] = pickFunct7();
			name = "immediate";
		end
		else if (cls == 5)
		begin
			instr[6:0] = 7'h37;
			name = "lui";
		end
		else
		begin
			if (instr[6:0] == 7'h33 || instr[6:0] == 7'h13 || instr[6:0] == 7'h37)
				instr[0] = 1'b0; // Force an unsupported opcode
			name = "unsupported opcode";
		end
	endtask

	// ADDI into the observed top register
	function automatic Word_t topRegisterWrite();
		Word_t r;
		r = $random(seed);
		return {r[31:20], 2'b00, r[2:0], 3'b000, 5'(numRegs - 1), 7'h13};
	endfunction

	initial
	begin
		#((totalSteps + 50) * 8);
		$display("Timeout: the test did not finish in the expected time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		Word_t instr;
		string name;
		logic valid;
		clock = 1'b0;
		reset = 1'b1;
		instruction = '0;
		instructionValid = 1'b0;
		expectValid = 1'b0;
		expectResult = '0;
		expectAddress = '0;
		expectName = "idle";
		expectTop = 1'b0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;

		repeat (3) @(posedge clock);
		@(negedge clock);
		checkValue("reset valid", 32'd0, Word_t'(resultValid));
		checkValue("reset x31", 32'd0, register31Output);
		reset = 1'b0;

		for (int i = 0; i < numInstructions; i++)
		begin
			generateInstruction(instr, name);
			valid = ($unsigned($random(seed)) % 8) != 0;
			applyStep(instr, valid, valid ? name : "idle", 1'b0);
			if (i % 64 == 63)
				applyStep(topRegisterWrite(), 1'b1, "x31 writeback", 1'b1);
		end
		applyStep(topRegisterWrite(), 1'b1, "x31 writeback", 1'b1);
		@(negedge clock);
		checkOutputs();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== sim/IntegerCore_props.sv ====
module IntegerCore_props import coreTypes::*;
(
	input logic clock,
	input logic reset,
	input DecodedOp_t decodedOp,
	input RegAddress_t destination,
	input Word_t rdData,
	input logic rdWriteEnable,
	input Word_t result,
	input logic resultValid,
	input RegAddress_t resultAddress
);

	// No result may leave the core while reset is held
	resultIdleInReset: assert property (@(posedge clock) reset |-> !resultValid)
	else
		$error("resultValid high during reset");

	// Result outputs carry what went to the write port
	resultMatchesWrite: assert property (@(posedge clock) disable iff (reset)
		rdWriteEnable |=> (result == $past(rdData)) && (resultAddress == $past(destination)))
	else
		$error("Registered result differs from the value written back");

	// One cycle from sampling to the result outputs
	resultFollowsWrite: assert property (@(posedge clock) disable iff (reset)
		(decodedOp.valid && decodedOp.writeEnable) |=> resultValid)
	else
		$error("Accepted instruction gave no resultValid on the next cycle");

endmodule

bind ExecuteUnit IntegerCore_props IntegerCore_props_inst
(
	.clock(clock),
	.reset(reset),
	.decodedOp(decodedOp),
	.destination(destination),
	.rdData(rdData),
	.rdWriteEnable(rdWriteEnable),
	.result(result),
	.resultValid(resultValid),
	.resultAddress(resultAddress)
);

// ==== verilog/ExecuteUnit.sv ====
module ExecuteUnit import coreTypes::*;
(
	input logic clock,
	input logic reset,

	input Word_t rs1,
	input Word_t rs2,
	input DecodedOp_t decodedOp,
	input RegAddress_t destination,

	// Writeback to the register file
	output Word_t rdData,
	output logic rdWriteEnable,

	// Registered result
	output Word_t result,
	output logic resultValid,
	output RegAddress_t resultAddress
);

	Word_t operandB;
	logic [4:0] shiftAmount;
	Word_t aluResult;

	assign operandB = decodedOp.useImmediate ? decodedOp.immediate : rs2;
	assign shiftAmount = operandB[4:0]; // Shamt for both OP and OP-IMM

	always_comb
	begin
		case (decodedOp.aluOp)
			opAdd:
				aluResult = rs1 + operandB;
			opSub:
				aluResult = rs1 - operandB;
			opSll:
				aluResult = rs1 << shiftAmount;
			opSlt:
				aluResult = Word_t'($signed(rs1) < $signed(operandB));
			opSltu:
				aluResult = Word_t'(rs1 < operandB);
			opXor:
				aluResult = rs1 ^ operandB;
			opSrl:
				aluResult = rs1 >> shiftAmount;
			opSra:
				aluResult = Word_t'($signed(rs1) >>> shiftAmount);
			opOr:
				aluResult = rs1 | operandB;
			opAnd:
				aluResult = rs1 & operandB;
			opPassB:
				aluResult = operandB;
			default:
				aluResult = '0;
		endcase
	end

	// Write port is driven straight from the ALU, committed at the same edge
	assign rdData = aluResult;
	assign rdWriteEnable = decodedOp.valid & decodedOp.writeEnable;

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			result <= '0;
			resultValid <= 1'b0;
			resultAddress <= '0;
		end
		else
		begin
			resultValid <= rdWriteEnable; // High for one cycle per instruction
			if (rdWriteEnable)
			begin
				result <= aluResult;
				resultAddress <= destination;
			end
		end
	end

endmodule

// ==== verilog/InstructionDecoder.sv ====
module InstructionDecoder import coreTypes::*;
(
	input Word_t instruction,
	input logic instructionValid,

	output DecodedAddresses_t decodedAddresses,
	output DecodedOp_t decodedOp
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic funct7Zero;
	logic altEncoding; // funct7 of 0100000, SUB and SRA(I)
	logic useAlt;
	Word_t immediateI;
	Word_t immediateU;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign funct7Zero = (funct7 == 7'b0000000);
	assign altEncoding = (funct7 == 7'b0100000);

	// Bit 30 is part of the immediate for ADDI, so only OP or shift-right looks at it
	assign useAlt = instruction[30] & ((opcode == opcodeOp) | (funct3 == 3'b101));

	assign immediateI = {{20{instruction[31]}}, instruction[31:20]};
	assign immediateU = {instruction[31:12], 12'h000};

	assign decodedAddresses.rs1Address = instruction[19:15];
	assign decodedAddresses.rs2Address = instruction[24:20];
	assign decodedAddresses.rdAddress = instruction[11:7];

	function automatic AluOp_t aluOpFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? opSub : opAdd;
			3'b001: return opSll;
			3'b010: return opSlt;
			3'b011: return opSltu;
			3'b100: return opXor;
			3'b101: return alt ? opSra : opSrl;
			3'b110: return opOr;
			default: return opAnd;
		endcase
	endfunction

	always_comb
	begin
		decodedOp.valid = instructionValid;
		decodedOp.aluOp = aluOpFromFunct3(funct3, useAlt);
		decodedOp.immediate = immediateI;
		decodedOp.useImmediate = 1'b0;
		decodedOp.writeEnable = 1'b0; // Dropped unless recognised below

		case (opcode)
			opcodeOp:
			begin
				if (funct7Zero)
					decodedOp.writeEnable = 1'b1;
				else if (altEncoding && (funct3 == 3'b000 || funct3 == 3'b101))
					decodedOp.writeEnable = 1'b1; // SUB, SRA
			end
			opcodeOpImm:
			begin
				decodedOp.useImmediate = 1'b1;
				if (funct3 == 3'b001)
					decodedOp.writeEnable = funct7Zero; // SLLI
				else if (funct3 == 3'b101)
					decodedOp.writeEnable = funct7Zero | altEncoding; // SRLI, SRAI
				else
					decodedOp.writeEnable = 1'b1;
			end
			opcodeLui:
			begin
				decodedOp.aluOp = opPassB;
				decodedOp.immediate = immediateU;
				decodedOp.useImmediate = 1'b1;
				decodedOp.writeEnable = 1'b1;
			end
			default:
			begin
				decodedOp.writeEnable = 1'b0;
			end
		endcase
	end

endmodule

// ==== verilog/IntegerCore.sv ====
module IntegerCore import coreTypes::*;
(
	input logic clock,
	input logic reset,

	input Word_t instruction,
	input logic instructionValid,

	output Word_t result,
	output logic resultValid,
	output RegAddress_t resultAddress,
	output Word_t register31Output
);

	DecodedAddresses_t decodedAddresses;
	DecodedOp_t decodedOp;
	Word_t rs1;
	Word_t rs2;
	Word_t rdData;
	logic rdWriteEnable;

	InstructionDecoder InstructionDecoder_inst
	(
		.instruction(instruction),
		.instructionValid(instructionValid),
		.decodedAddresses(decodedAddresses),
		.decodedOp(decodedOp)
	);

	RegisterFile RegisterFile_inst
	(
		.clock(clock),
		.reset(reset),
		.decodedAddresses(decodedAddresses),
		.rdData(rdData),
		.rdWriteEnable(rdWriteEnable),
		.rs1(rs1),
		.rs2(rs2),
		.register31Output(register31Output)
	);

	ExecuteUnit ExecuteUnit_inst
	(
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.decodedOp(decodedOp),
		.destination(decodedAddresses.rdAddress),
		.rdData(rdData),
		.rdWriteEnable(rdWriteEnable),
		.result(result),
		.resultValid(resultValid),
		.resultAddress(resultAddress)
	);

endmodule

// ==== verilog/RegisterFile.sv ====
module RegisterFile import coreTypes::*;
(
	input logic clock,
	input logic reset,

	input DecodedAddresses_t decodedAddresses,

	// Write port
	input Word_t rdData,
	input logic rdWriteEnable,

	// Read ports
	output Word_t rs1,
	output Word_t rs2,
	output Word_t register31Output
);

	Word_t registers [1:numRegs-1]; // x0 is not stored
	RegAddress_t rs1Index;
	RegAddress_t rs2Index;
	RegAddress_t rdIndex;

	// RV32E ignores the top address bit
	function automatic RegAddress_t effectiveAddress(input RegAddress_t address);
		if (rv32i)
			return address;
		else
			return {1'b0, address[3:0]};
	endfunction

	// Flat one-level mux over every register, zero for x0
	function automatic Word_t readRegister(input Word_t regs [1:numRegs-1],
		input RegAddress_t index);
		Word_t value;
		value = '0;
		for (int i = 1; i < numRegs; i++)
		begin
			if (index == RegAddress_t'(i))
				value = regs[i];
		end
		return value;
	endfunction

	assign rs1Index = effectiveAddress(decodedAddresses.rs1Address);
	assign rs2Index = effectiveAddress(decodedAddresses.rs2Address);
	assign rdIndex = effectiveAddress(decodedAddresses.rdAddress);

	assign rs1 = readRegister(registers, rs1Index);
	assign rs2 = readRegister(registers, rs2Index);

	assign register31Output = registers[numRegs-1]; // x31, or x15 for RV32E

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < numRegs; i++)
				registers[i] <= '0;
		end
		else if (rdWriteEnable && rdIndex != '0) // Writes to x0 vanish here
		begin
			registers[rdIndex] <= rdData;
		end
	end

endmodule

// ==== verilog/coreTypes.sv ====
package coreTypes;

	localparam bit rv32i = 1'b1; // 1 for RV32I, 0 for RV32E
	localparam int numRegs = rv32i ? 32 : 16;
	localparam int xLen = 32;

	typedef logic [xLen-1:0] Word_t;
	typedef logic [4:0] RegAddress_t;
	typedef logic [3:0] AluOp_t;

	// Major opcodes handled by the slice
	localparam logic [6:0] opcodeOp = 7'b0110011;
	localparam logic [6:0] opcodeOpImm = 7'b0010011;
	localparam logic [6:0] opcodeLui = 7'b0110111;

	localparam AluOp_t opAdd = 4'd0;
	localparam AluOp_t opSub = 4'd1;
	localparam AluOp_t opSll = 4'd2;
	localparam AluOp_t opSlt = 4'd3;
	localparam AluOp_t opSltu = 4'd4;
	localparam AluOp_t opXor = 4'd5;
	localparam AluOp_t opSrl = 4'd6;
	localparam AluOp_t opSra = 4'd7;
	localparam AluOp_t opOr = 4'd8;
	localparam AluOp_t opAnd = 4'd9;
	localparam AluOp_t opPassB = 4'd10; // LUI

	typedef struct packed
	{
		RegAddress_t rs1Address;
		RegAddress_t rs2Address;
		RegAddress_t rdAddress;
	} DecodedAddresses_t;

	typedef struct packed
	{
		AluOp_t aluOp;
		Word_t immediate;
		logic useImmediate; // Operand B from immediate instead of rs2
		logic writeEnable; // Supported and legal encoding
		logic valid;
	} DecodedOp_t;

endpackage
